// File: list.f
src/periph_pkg.sv
src/periph_decode.sv
src/irq_ctrl.sv
src/periph_timer.sv
src/periph_result.sv
src/periph_top.sv
testbench/periph_props.sv
testbench/tb_periph_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_periph_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Errors found

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: testbench/tb_periph_top.sv
// --------------------
// Testbench for the peripheral block, random
// bus traffic checked against a reference model
// --------------------
`timescale 1ns/1ps

module tb_periph_top
    import periph_pkg::*;
();

    localparam int          NUM_EXT_IRQ = 8;
    localparam int          NUM_TIMERS  = 2;
    localparam int          PRIO_W      = 3;
    localparam int          NSRC        = NUM_EXT_IRQ + NUM_TIMERS;
    localparam int          LIMIT       = 200;
    localparam logic [31:0] SEED        = 32'hc92e;

    logic                   clk_i;
    logic                   rst_n_i;
    reg_req_t               req_i;
    logic                   req_valid_i;
    logic                   req_ready_o;
    reg_rsp_t               rsp_o;
    logic                   rsp_valid_o;
    logic                   rsp_ready_i;
    logic [NUM_EXT_IRQ-1:0] ext_irq_i;
    logic                   irq_o;

    // Reference model state, bit k of a mask is source id k
    logic [PRIO_W-1:0]      m_prio [1:NSRC];
    logic [NSRC:1]          m_en;
    logic [PRIO_W-1:0]      m_thr;
    logic [NSRC:1]          m_claimed;
    logic [NUM_TIMERS-1:0]  m_ten;
    logic [NUM_TIMERS-1:0]  m_stat;
    logic [DATA_W-1:0]      m_cnt [NUM_TIMERS];
    logic [DATA_W-1:0]      m_cmp [NUM_TIMERS];
    reg_rsp_t               exp_q [$];
    reg_rsp_t               last_rsp;
    logic                   hs_prev;

    int seed;
    int rdy_seed;
    int ready_pct;
    int n_req;
    int n_rsp;
    int n_chk;
    int n_err;

    periph_top #(
        .NUM_EXT_IRQ ( NUM_EXT_IRQ ),
        .NUM_TIMERS  ( NUM_TIMERS  ),
        .PRIO_W      ( PRIO_W      )
    ) DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        rsp_ready_i <= ({$random(rdy_seed)} % 100) < ready_pct;
    end

    // --------------------
    // Model rules
    // --------------------
    function automatic logic [NSRC:1] pending();
        return {ext_irq_i, m_stat} & ~m_claimed;
    endfunction

    // Highest priority wins, lowest id on a tie
    function automatic int win_id();
        logic [NSRC:1]     p;
        logic [PRIO_W-1:0] best;
        int                id;
        p    = pending();
        best = '0;
        id   = 0;
        for (int k = 1; k <= NSRC; k++) begin
            if (p[k] && m_en[k] && m_prio[k] > best) begin
                best = m_prio[k];
                id   = k;
            end
        end
        return id;
    endfunction

    function automatic logic irq_expected();
        int id;
        id = win_id();
        if (id == 0) return 1'b0;
        return m_prio[id] > m_thr;
    endfunction

    function automatic reg_rsp_t expect_rsp(reg_req_t r);
        reg_rsp_t    e;
        logic [11:0] ofs;
        int          id;
        int          t;
        e   = '0;
        ofs = r.addr[11:0];
        id  = int'(ofs[11:2]);
        t   = int'(ofs[11:4]);
        if (r.addr[1:0] != 2'b00 || r.addr[15:12] > 4'd1) begin
            e.error = 1'b1;
            e.rdata = ERR_RDATA;
        end else if (r.addr[15:12] == 4'd0) begin
            if (id >= 1 && id <= NSRC) e.rdata = 32'(m_prio[id]);
            else if (ofs == IRQ_PENDING_OFS[11:0]) e.rdata = 32'({pending(), 1'b0});
            else if (ofs == IRQ_ENABLE_OFS[11:0]) e.rdata = 32'({m_en, 1'b0});
            else if (ofs == IRQ_THRESH_OFS[11:0]) e.rdata = 32'(m_thr);
            else if (ofs == IRQ_CLAIM_OFS[11:0]) e.rdata = irq_expected() ? 32'(win_id()) : '0;
            else e.error = 1'b1;
        end else if (t < NUM_TIMERS && ofs[3:0] == TMR_CTRL_OFS[3:0]) begin
            e.rdata = 32'({m_stat[t], 1'b0, m_ten[t]});
        end else if (t < NUM_TIMERS && ofs[3:0] == TMR_COUNT_OFS[3:0]) begin
            e.rdata = m_cnt[t];
        end else if (t < NUM_TIMERS && ofs[3:0] == TMR_CMP_OFS[3:0]) begin
            e.rdata = m_cmp[t];
        end else begin
            e.error = 1'b1;
        end
        if (r.write) e.rdata = '0;
        return e;
    endfunction

    // One clock edge of the model, hs marks a request handshake
    task automatic advance_model(logic hs, reg_req_t r);
        logic [11:0] ofs;
        int          id;
        int          t;
        int          w;
        logic        irq_now;
        ofs     = r.addr[11:0];
        id      = int'(ofs[11:2]);
        t       = int'(ofs[11:4]);
        w       = win_id();
        irq_now = irq_expected();
        if (hs && r.addr[1:0] == 2'b00 && r.addr[15:12] == 4'd0) begin
            if (r.write && id >= 1 && id <= NSRC) m_prio[id] = r.wdata[PRIO_W-1:0];
            if (r.write && ofs == IRQ_ENABLE_OFS[11:0]) m_en = r.wdata[NSRC:1];
            if (r.write && ofs == IRQ_THRESH_OFS[11:0]) m_thr = r.wdata[PRIO_W-1:0];
            if (ofs == IRQ_CLAIM_OFS[11:0]) begin
                if (r.write && r.wdata[3:0] >= 1 && r.wdata[3:0] <= NSRC) begin
                    m_claimed[r.wdata[3:0]] = 1'b0;
                end else if (!r.write && irq_now) begin
                    m_claimed[w] = 1'b1;
                end
            end
        end
        for (int k = 0; k < NUM_TIMERS; k++) begin
            if (m_ten[k] && m_cnt[k] == m_cmp[k]) begin
                m_cnt[k]  = '0;
                m_stat[k] = 1'b1;
            end else if (m_ten[k]) begin
                m_cnt[k] = m_cnt[k] + 32'd1;
            end
        end
        if (hs && r.write && r.addr[1:0] == 2'b00 && r.addr[15:12] == 4'd1
                && t < NUM_TIMERS) begin
            case (ofs[3:0])
                TMR_CTRL_OFS[3:0]: begin
                    m_ten[t] = r.wdata[0];
                    if (r.wdata[1]) m_stat[t] = 1'b0;
                end
                TMR_COUNT_OFS[3:0]: m_cnt[t] = r.wdata;
                TMR_CMP_OFS[3:0]:   m_cmp[t] = r.wdata;
                default: ;
            endcase
        end
    endtask

    // --------------------
    // Checks and bus tasks
    // --------------------
    task automatic check_rsp(reg_rsp_t got, reg_rsp_t exp);
        n_chk++;
        if (got !== exp) begin
            n_err++;
            $display("Error at %0t ns: response rdata %h error %b, expected rdata %h error %b",
                     $time, got.rdata, got.error, exp.rdata, exp.error);
        end
    endtask

    task automatic check_irq(logic got, logic exp);
        n_chk++;
        if (got !== exp) begin
            n_err++;
            $display("Error at %0t ns: irq_o is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic abort_run(string why);
        $display("Timeout while waiting for %s at %0t ns", why, $time);
        $display("Errors found");
        $finish;
    endtask

    // Sampled at the falling edge, where every output is settled
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            check_irq(irq_o, irq_expected());
            if (hs_prev && !rsp_valid_o) begin
                n_err++;
                $display("No response one cycle after the request handshake at %0t ns",
                         $time);
            end
            if (rsp_valid_o && rsp_ready_i) begin
                n_rsp++;
                last_rsp = rsp_o;
                if (exp_q.size() == 0) begin
                    n_err++;
                    $display("A response came back with no request outstanding at %0t ns",
                             $time);
                end else begin
                    check_rsp(rsp_o, exp_q.pop_front());
                end
            end
            if (req_valid_i && req_ready_o) begin
                n_req++;
                exp_q.push_back(expect_rsp(req_i));
            end
            hs_prev = req_valid_i && req_ready_o;
            advance_model(req_valid_i && req_ready_o, req_i);
        end
    end

    // Leaves valid high so that the next call goes back to back
    task automatic bus_op(logic [ADDR_W-1:0] addr, logic write, logic [DATA_W-1:0] wdata);
        int cnt;
        req_i       <= '{addr: addr, write: write, wdata: wdata};
        req_valid_i <= 1'b1;
        cnt = 0;
        @(negedge clk_i);
        while (!req_ready_o) begin
            cnt++;
            if (cnt == LIMIT) abort_run("the request handshake");
            @(negedge clk_i);
        end
        @(posedge clk_i);
    endtask

    task automatic idle(int n);
        req_valid_i <= 1'b0;
        repeat (n) @(posedge clk_i);
    endtask

    task automatic wait_drain();
        int cnt;
        req_valid_i <= 1'b0;
        cnt = 0;
        @(posedge clk_i);
        while (exp_q.size() != 0) begin
            cnt++;
            if (cnt == LIMIT) abort_run("outstanding responses");
            @(posedge clk_i);
        end
    endtask

    task automatic read_reg(logic [ADDR_W-1:0] addr, output reg_rsp_t r);
        bus_op(addr, 1'b0, '0);
        wait_drain();
        r = last_rsp;
    endtask

    task automatic report_test(int num, string name);
        $display("Test %0d %s finished, %0d errors so far", num, name, n_err);
    endtask

    function automatic logic [ADDR_W-1:0] pick_reg(logic [31:0] rnd);
        case (rnd[2:0])
            3'd0, 3'd1: return IRQ_BASE + ADDR_W'(4 * (1 + rnd[15:8] % NSRC));
            3'd2:       return IRQ_BASE + IRQ_ENABLE_OFS;
            3'd3:       return IRQ_BASE + IRQ_THRESH_OFS;
            3'd4:       return IRQ_BASE + IRQ_PENDING_OFS;
            default:    return TIMER_BASE + TIMER_STRIDE * ADDR_W'(rnd[8]) + TMR_CMP_OFS;
        endcase
    endfunction

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        reg_rsp_t          rsp;
        logic [31:0]       rnd;
        logic [31:0]       wd;
        logic [ADDR_W-1:0] addr;
        int                polls;
        seed        = SEED;
        rdy_seed    = SEED ^ 32'h5a5a;
        ready_pct   = 100;
        n_req       = 0;
        n_rsp       = 0;
        n_chk       = 0;
        n_err       = 0;
        rst_n_i     = 1'b0;
        req_i       = '0;
        req_valid_i = 1'b0;
        rsp_ready_i = 1'b0;
        ext_irq_i   = '0;
        last_rsp    = '0;
        hs_prev     = 1'b0;
        for (int k = 1; k <= NSRC; k++) m_prio[k] = '0;
        m_en      = '0;
        m_thr     = '0;
        m_claimed = '0;
        m_ten     = '0;
        m_stat    = '0;
        for (int k = 0; k < NUM_TIMERS; k++) begin
            m_cnt[k] = '0;
            m_cmp[k] = '0;
        end
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;

        ready_pct = 70;
        for (int i = 0; i < 200; i++) begin
            rnd = $random(seed);
            wd  = $random(seed);
            bus_op(pick_reg(rnd), rnd[3], wd);
        end
        wait_drain();
        report_test(1, "register read-back");

        for (int i = 0; i < 60; i++) begin
            rnd = $random(seed);
            wd  = $random(seed);
            if (rnd[0]) addr = {4'(2 + rnd[7:4] % 14), rnd[19:8]};
            else addr = {3'b000, rnd[13:3], rnd[21], 1'b1};
            bus_op(addr, rnd[2], wd);
        end
        for (int id = 1; id <= NSRC; id++) bus_op(IRQ_BASE + ADDR_W'(4 * id), 1'b0, '0);
        bus_op(IRQ_BASE + IRQ_ENABLE_OFS, 1'b0, '0);
        bus_op(IRQ_BASE + IRQ_THRESH_OFS, 1'b0, '0);
        bus_op(TIMER_BASE + TMR_CMP_OFS, 1'b0, '0);
        bus_op(TIMER_BASE + TIMER_STRIDE + TMR_CMP_OFS, 1'b0, '0);
        wait_drain();
        report_test(2, "error responder");

        bus_op(IRQ_BASE + IRQ_ENABLE_OFS, 1'b1, 32'h7fe);
        bus_op(IRQ_BASE + IRQ_THRESH_OFS, 1'b1, 32'h0);
        for (int i = 0; i < 300; i++) begin
            rnd = $random(seed);
            wd  = $random(seed);
            if (rnd[3:0] == 4'd0) ext_irq_i <= rnd[15:8];
            case (rnd[6:4])
                3'd0:       bus_op(IRQ_BASE + IRQ_CLAIM_OFS, 1'b1, 32'(1 + wd % NSRC));
                3'd3:       bus_op(IRQ_BASE + IRQ_PENDING_OFS, 1'b0, '0);
                3'd4:       bus_op(IRQ_BASE + ADDR_W'(4 * (1 + wd[15:8] % NSRC)), 1'b1, wd);
                3'd5:       bus_op(IRQ_BASE + IRQ_THRESH_OFS, 1'b1, 32'(wd[1:0]));
                default:    bus_op(IRQ_BASE + IRQ_CLAIM_OFS, 1'b0, '0);
            endcase
        end
        wait_drain();
        report_test(3, "claim and complete");

        for (int i = 0; i < 100; i++) begin
            rnd = $random(seed);
            ext_irq_i <= rnd[7:0];
            bus_op(IRQ_BASE + IRQ_THRESH_OFS, 1'b1, 32'(rnd[10:8]));
            idle(2);
        end
        wait_drain();
        report_test(4, "irq_o rule");

        // Timer 0 alone as source id 1
        ready_pct = 100;
        ext_irq_i <= '0;
        for (int id = 1; id <= NSRC; id++) bus_op(IRQ_BASE + IRQ_CLAIM_OFS, 1'b1, 32'(id));
        bus_op(IRQ_BASE + IRQ_ENABLE_OFS, 1'b1, 32'h2);
        bus_op(IRQ_BASE + IRQ_THRESH_OFS, 1'b1, 32'h0);
        bus_op(IRQ_BASE + 16'h4, 1'b1, 32'h5);
        bus_op(TIMER_BASE + TMR_COUNT_OFS, 1'b1, 32'h0);
        bus_op(TIMER_BASE + TMR_CMP_OFS, 1'b1, 32'h6);
        bus_op(TIMER_BASE + TMR_CTRL_OFS, 1'b1, 32'h1);
        polls = 0;
        rsp   = '0;
        while (!rsp.rdata[2]) begin
            polls++;
            if (polls == LIMIT) abort_run("the timer status bit");
            read_reg(TIMER_BASE + TMR_CTRL_OFS, rsp);
        end
        @(negedge clk_i);
        check_irq(irq_o, 1'b1);
        @(posedge clk_i);
        read_reg(IRQ_BASE + IRQ_CLAIM_OFS, rsp);
        check_rsp(rsp, '{rdata: 32'd1, error: 1'b0});
        bus_op(TIMER_BASE + TMR_CTRL_OFS, 1'b1, 32'h2);
        bus_op(IRQ_BASE + IRQ_CLAIM_OFS, 1'b1, 32'h1);
        idle(3);
        @(negedge clk_i);
        check_irq(irq_o, 1'b0);
        @(posedge clk_i);
        report_test(5, "timers");

        ready_pct = 30;
        for (int i = 0; i < 200; i++) begin
            rnd = $random(seed);
            wd  = $random(seed);
            bus_op(pick_reg(rnd), rnd[3], wd);
        end
        wait_drain();
        if (n_req != n_rsp) begin
            n_err++;
            $display("Sent %0d requests but received %0d responses", n_req, n_rsp);
        end
        report_test(6, "back-pressure");

        $display("Done: %0d checks, %0d errors, %0d requests, %0d responses",
                 n_chk, n_err, n_req, n_rsp);
        if (n_err == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: testbench/periph_props.sv
// --------------------
// Bus handshake assertions, bound to periph_top
// --------------------
`timescale 1ns/1ps

module periph_props
    import periph_pkg::*;
(
    input logic     clk_i,
    input logic     rst_n_i,
    input logic     req_valid_i,
    input logic     req_ready_o,
    input reg_rsp_t rsp_o,
    input logic     rsp_valid_o,
    input logic     rsp_ready_i
);

    // Held response keeps valid and payload
    rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o))
        else $error("rsp_o changed while the response was held");

    ready_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_o && !rsp_ready_i |-> !req_ready_o)
        else $error("req_ready_o high while a response was held");

    rsp_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(rsp_valid_o) |-> $past(req_valid_i && req_ready_o))
        else $error("rsp_valid_o rose without a request handshake one cycle before");

endmodule

bind periph_top periph_props i_props (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .req_valid_i ( req_valid_i ),
    .req_ready_o ( req_ready_o ),
    .rsp_o       ( rsp_o       ),
    .rsp_valid_o ( rsp_valid_o ),
    .rsp_ready_i ( rsp_ready_i )
);

// File: src/periph_top.sv
// --------------------
// Peripheral block top level, decoder,
// interrupt controller, timers and response stage
// --------------------
`timescale 1ns/1ps

module periph_top
    import periph_pkg::*;
#(
    parameter int NUM_EXT_IRQ = 8,
    parameter int NUM_TIMERS  = 2,
    parameter int PRIO_W      = 3
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  reg_req_t               req_i,
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    output reg_rsp_t               rsp_o,
    output logic                   rsp_valid_o,
    input  logic                   rsp_ready_i,
    input  logic [NUM_EXT_IRQ-1:0] ext_irq_i,
    output logic                   irq_o
);

    localparam int NUM_SRC = NUM_TIMERS + NUM_EXT_IRQ;

    target_e               tgt;
    logic [OFS_W-1:0]      offset;
    logic                  accept;
    logic                  strobe;
    logic                  irq_strobe;
    logic                  tmr_strobe;
    reg_rsp_t              irq_rsp;
    reg_rsp_t              tmr_rsp;
    logic [NUM_TIMERS-1:0] match;
    logic [NUM_SRC-1:0]    src;

    // Timers take the low ids, external lines follow
    assign src = {ext_irq_i, match};

    assign irq_strobe = strobe && (tgt == TGT_IRQ);
    assign tmr_strobe = strobe && (tgt == TGT_TIMER);

    // --------------------
    // Decode
    // --------------------
    periph_decode i_decode (
        .req_i    ( req_i  ),
        .accept_i ( accept ),
        .tgt_o    ( tgt    ),
        .offset_o ( offset ),
        .strobe_o ( strobe )
    );

    // --------------------
    // Execute
    // --------------------
    irq_ctrl #(
        .NUM_SRC ( NUM_SRC ),
        .PRIO_W  ( PRIO_W  )
    ) i_irq_ctrl (
        .clk_i    ( clk_i      ),
        .rst_n_i  ( rst_n_i    ),
        .req_i    ( req_i      ),
        .offset_i ( offset     ),
        .strobe_i ( irq_strobe ),
        .src_i    ( src        ),
        .rsp_o    ( irq_rsp    ),
        .irq_o    ( irq_o      )
    );

    periph_timer #(
        .NUM_TIMERS ( NUM_TIMERS )
    ) i_timer (
        .clk_i    ( clk_i      ),
        .rst_n_i  ( rst_n_i    ),
        .req_i    ( req_i      ),
        .offset_i ( offset     ),
        .strobe_i ( tmr_strobe ),
        .rsp_o    ( tmr_rsp    ),
        .match_o  ( match      )
    );

    // --------------------
    // Result
    // --------------------
    periph_result i_result (
        .clk_i       ( clk_i       ),
        .rst_n_i     ( rst_n_i     ),
        .req_valid_i ( req_valid_i ),
        .tgt_i       ( tgt         ),
        .irq_rsp_i   ( irq_rsp     ),
        .tmr_rsp_i   ( tmr_rsp     ),
        .write_i     ( req_i.write ),
        .rsp_ready_i ( rsp_ready_i ),
        .req_ready_o ( req_ready_o ),
        .accept_o    ( accept      ),
        .rsp_o       ( rsp_o       ),
        .rsp_valid_o ( rsp_valid_o )
    );

endmodule

// File: src/periph_result.sv
// --------------------
// Response register with error responder
// and request back-pressure
// --------------------
`timescale 1ns/1ps

module periph_result
    import periph_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     req_valid_i,
    input  target_e  tgt_i,
    input  reg_rsp_t irq_rsp_i,
    input  reg_rsp_t tmr_rsp_i,
    input  logic     write_i,
    input  logic     rsp_ready_i,
    output logic     req_ready_o,
    output logic     accept_o,
    output reg_rsp_t rsp_o,
    output logic     rsp_valid_o
);

    reg_rsp_t rsp_sel;
    reg_rsp_t rsp_q;
    logic     rsp_valid_q;

    // Free slot, or the held response leaves this cycle
    assign req_ready_o = !rsp_valid_q || rsp_ready_i;
    assign accept_o    = req_valid_i && req_ready_o;

    always_comb begin
        case (tgt_i)
            TGT_IRQ:   rsp_sel = irq_rsp_i;
            TGT_TIMER: rsp_sel = tmr_rsp_i;
            default: begin
                rsp_sel.error = 1'b1;
                rsp_sel.rdata = write_i ? '0 : ERR_RDATA;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_q       <= '0;
            rsp_valid_q <= 1'b0;
        end else if (accept_o) begin
            rsp_q       <= rsp_sel;
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    assign rsp_o       = rsp_q;
    assign rsp_valid_o = rsp_valid_q;

endmodule

// File: src/periph_timer.sv
// --------------------
// Bank of compare timers with sticky
// match status
// --------------------
`timescale 1ns/1ps

module periph_timer
    import periph_pkg::*;
#(
    parameter int NUM_TIMERS = 2
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  reg_req_t              req_i,
    input  logic [OFS_W-1:0]      offset_i,
    input  logic                  strobe_i,
    output reg_rsp_t              rsp_o,
    output logic [NUM_TIMERS-1:0] match_o
);

    localparam int STRIDE_LSB = $clog2(TIMER_STRIDE);

    logic [NUM_TIMERS-1:0] en_q;
    logic [NUM_TIMERS-1:0] status_q;
    logic [DATA_W-1:0]     count_q [NUM_TIMERS];
    logic [DATA_W-1:0]     cmp_q [NUM_TIMERS];

    logic [NUM_TIMERS-1:0] sel;
    logic [STRIDE_LSB-1:0] reg_ofs;
    logic                  is_ctrl;
    logic                  is_count;
    logic                  is_cmp;
    logic                  wr_en;

    always_comb begin
        for (int t = 0; t < NUM_TIMERS; t++) begin
            sel[t] = offset_i[OFS_W-1:STRIDE_LSB] == (OFS_W-STRIDE_LSB)'(t);
        end
    end

    assign reg_ofs  = offset_i[STRIDE_LSB-1:0];
    assign is_ctrl  = reg_ofs == TMR_CTRL_OFS[STRIDE_LSB-1:0];
    assign is_count = reg_ofs == TMR_COUNT_OFS[STRIDE_LSB-1:0];
    assign is_cmp   = reg_ofs == TMR_CMP_OFS[STRIDE_LSB-1:0];
    assign wr_en    = strobe_i && req_i.write;

    // --------------------
    // Read path
    // --------------------
    always_comb begin
        rsp_o = '0;
        if (!(|sel) || !(is_ctrl || is_count || is_cmp)) begin
            rsp_o.error = 1'b1;
        end else if (!req_i.write) begin
            for (int t = 0; t < NUM_TIMERS; t++) begin
                if (sel[t]) begin
                    if (is_ctrl) begin
                        // Bit 1 is the status clear, it always reads as zero
                        rsp_o.rdata = DATA_W'({status_q[t], 1'b0, en_q[t]});
                    end else if (is_count) begin
                        rsp_o.rdata = count_q[t];
                    end else begin
                        rsp_o.rdata = cmp_q[t];
                    end
                end
            end
        end
    end

    // Counters, a bus write in the same cycle wins
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q     <= '0;
            status_q <= '0;
            for (int t = 0; t < NUM_TIMERS; t++) begin
                count_q[t] <= '0;
                cmp_q[t]   <= '0;
            end
        end else begin
            for (int t = 0; t < NUM_TIMERS; t++) begin
                if (en_q[t]) begin
                    if (count_q[t] == cmp_q[t]) begin
                        count_q[t]  <= '0;
                        status_q[t] <= 1'b1;
                    end else begin
                        count_q[t] <= count_q[t] + 1'b1;
                    end
                end
                if (wr_en && sel[t]) begin
                    if (is_ctrl) begin
                        en_q[t] <= req_i.wdata[0];
                        if (req_i.wdata[1]) begin
                            status_q[t] <= 1'b0;
                        end
                    end
                    if (is_count) begin
                        count_q[t] <= req_i.wdata;
                    end
                    if (is_cmp) begin
                        cmp_q[t] <= req_i.wdata;
                    end
                end
            end
        end
    end

    assign match_o = status_q;

endmodule

// File: src/irq_ctrl.sv
// --------------------
// Level interrupt controller with priority,
// enable mask, threshold and claim/complete
// --------------------
`timescale 1ns/1ps

module irq_ctrl
    import periph_pkg::*;
#(
    parameter int NUM_SRC = 10,
    parameter int PRIO_W  = 3
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  reg_req_t           req_i,
    input  logic [OFS_W-1:0]   offset_i,
    input  logic               strobe_i,
    input  logic [NUM_SRC-1:0] src_i,
    output reg_rsp_t           rsp_o,
    output logic               irq_o
);

    localparam int ID_W = $clog2(NUM_SRC + 1);

    // Bit k of each mask belongs to source id k+1
    logic [PRIO_W-1:0]  prio_q [NUM_SRC];
    logic [NUM_SRC-1:0] enable_q;
    logic [PRIO_W-1:0]  thresh_q;
    logic [NUM_SRC-1:0] claimed_q;

    logic [NUM_SRC-1:0] pending;
    logic [ID_W-1:0]    win_id;
    logic [PRIO_W-1:0]  win_prio;
    logic [NUM_SRC-1:0] prio_sel;
    logic               prio_hit;
    logic               is_pend;
    logic               is_en;
    logic               is_thr;
    logic               is_claim;
    logic               wr_en;
    logic               rd_claim;
    logic [ID_W-1:0]    cmpl_id;

    assign pending = src_i & ~claimed_q;

    // --------------------
    // Winner search
    // --------------------
    // Strict compare keeps the lowest id on equal priority
    always_comb begin
        win_id   = '0;
        win_prio = '0;
        for (int i = 0; i < NUM_SRC; i++) begin
            if (pending[i] && enable_q[i] && (prio_q[i] > win_prio)) begin
                win_id   = ID_W'(i + 1);
                win_prio = prio_q[i];
            end
        end
    end

    assign irq_o = win_prio > thresh_q;

    // Offset decode
    always_comb begin
        for (int i = 0; i < NUM_SRC; i++) begin
            prio_sel[i] = offset_i[OFS_W-1:2] == (OFS_W-2)'(i + 1);
        end
    end

    assign prio_hit = |prio_sel;
    assign is_pend  = offset_i == IRQ_PENDING_OFS[OFS_W-1:0];
    assign is_en    = offset_i == IRQ_ENABLE_OFS[OFS_W-1:0];
    assign is_thr   = offset_i == IRQ_THRESH_OFS[OFS_W-1:0];
    assign is_claim = offset_i == IRQ_CLAIM_OFS[OFS_W-1:0];

    // --------------------
    // Response
    // --------------------
    always_comb begin
        rsp_o = '0;
        if (prio_hit) begin
            for (int i = 0; i < NUM_SRC; i++) begin
                if (prio_sel[i]) begin
                    rsp_o.rdata = DATA_W'(prio_q[i]);
                end
            end
        end else if (is_pend) begin
            rsp_o.rdata = DATA_W'({pending, 1'b0});
        end else if (is_en) begin
            rsp_o.rdata = DATA_W'({enable_q, 1'b0});
        end else if (is_thr) begin
            rsp_o.rdata = DATA_W'(thresh_q);
        end else if (is_claim) begin
            rsp_o.rdata = irq_o ? DATA_W'(win_id) : '0;
        end else begin
            rsp_o.error = 1'b1;
        end
        if (req_i.write) begin
            rsp_o.rdata = '0;
        end
    end

    assign wr_en    = strobe_i && req_i.write;
    assign rd_claim = strobe_i && !req_i.write && is_claim && irq_o;
    assign cmpl_id  = req_i.wdata[ID_W-1:0];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_SRC; i++) begin
                prio_q[i] <= '0;
            end
            enable_q  <= '0;
            thresh_q  <= '0;
            claimed_q <= '0;
        end else begin
            if (wr_en) begin
                for (int i = 0; i < NUM_SRC; i++) begin
                    if (prio_sel[i]) begin
                        prio_q[i] <= req_i.wdata[PRIO_W-1:0];
                    end
                    // Complete
                    if (is_claim && (cmpl_id == ID_W'(i + 1))) begin
                        claimed_q[i] <= 1'b0;
                    end
                end
                if (is_en) begin
                    enable_q <= req_i.wdata[NUM_SRC:1];
                end
                if (is_thr) begin
                    thresh_q <= req_i.wdata[PRIO_W-1:0];
                end
            end
            if (rd_claim) begin
                for (int i = 0; i < NUM_SRC; i++) begin
                    if (win_id == ID_W'(i + 1)) begin
                        claimed_q[i] <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: src/periph_decode.sv
// --------------------
// Address decoder, picks the target region
// and the region-relative word offset
// --------------------
`timescale 1ns/1ps

module periph_decode
    import periph_pkg::*;
(
    input  reg_req_t         req_i,
    input  logic             accept_i,
    output target_e          tgt_o,
    output logic [OFS_W-1:0] offset_o,
    output logic             strobe_o
);

    logic [ADDR_W-OFS_W-1:0] region;
    logic                    misaligned;
    logic                    hit_irq;
    logic                    hit_timer;

    assign region     = req_i.addr[ADDR_W-1:OFS_W];
    assign misaligned = |req_i.addr[1:0];

    assign hit_irq   = region == IRQ_BASE[ADDR_W-1:OFS_W];
    assign hit_timer = region == TIMER_BASE[ADDR_W-1:OFS_W];

    // --------------------
    // Target select
    // --------------------
    always_comb begin
        if (misaligned) begin
            tgt_o = TGT_NONE;
        end else if (hit_irq) begin
            tgt_o = TGT_IRQ;
        end else if (hit_timer) begin
            tgt_o = TGT_TIMER;
        end else begin
            tgt_o = TGT_NONE;
        end
    end

    assign offset_o = req_i.addr[OFS_W-1:0];

    // Error responder needs no strobe, it is handled in the result stage
    assign strobe_o = accept_i && (tgt_o != TGT_NONE);

endmodule

// File: src/periph_pkg.sv
// --------------------
// Shared bus structs, address map and
// target encoding for the peripheral block
// --------------------
package periph_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 16;
    // Byte offset width inside one 4 KiB region
    localparam int OFS_W  = 12;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              write;
        logic [DATA_W-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic              error;
    } reg_rsp_t;

    typedef enum logic [1:0] {
        TGT_IRQ   = 2'd0,
        TGT_TIMER = 2'd1,
        TGT_NONE  = 2'd2
    } target_e;

    // --------------------
    // Address map
    // --------------------
    localparam logic [ADDR_W-1:0] IRQ_BASE   = 16'h0000;
    localparam logic [ADDR_W-1:0] TIMER_BASE = 16'h1000;

    // Interrupt controller, priority of id k sits at 4*k
    localparam logic [ADDR_W-1:0] IRQ_PENDING_OFS = 16'h0100;
    localparam logic [ADDR_W-1:0] IRQ_ENABLE_OFS  = 16'h0104;
    localparam logic [ADDR_W-1:0] IRQ_THRESH_OFS  = 16'h0108;
    localparam logic [ADDR_W-1:0] IRQ_CLAIM_OFS   = 16'h010C;

    // Timer bank
    localparam logic [ADDR_W-1:0] TIMER_STRIDE  = 16'h0010;
    localparam logic [ADDR_W-1:0] TMR_CTRL_OFS  = 16'h0000;
    localparam logic [ADDR_W-1:0] TMR_COUNT_OFS = 16'h0004;
    localparam logic [ADDR_W-1:0] TMR_CMP_OFS   = 16'h0008;

    localparam logic [DATA_W-1:0] ERR_RDATA = 32'hdeadbeef;

endpackage
